//--- smc_lite.f
verilog/smc_cfg_pkg.sv
verilog/smc_mem_pkg.sv
verilog/smc_apb_if.sv
verilog/smc_cfreg.sv
verilog/smc_wb_if.sv
verilog/smc_strobe_gen.sv
verilog/smc_lite.sv
bench/sram_model.sv
bench/smc_lite_tb.sv

//--- Bender.yml
package:
  name: smc_lite

sources:
  - verilog/smc_cfg_pkg.sv
  - verilog/smc_mem_pkg.sv
  - verilog/smc_apb_if.sv
  - verilog/smc_cfreg.sv
  - verilog/smc_wb_if.sv
  - verilog/smc_strobe_gen.sv
  - verilog/smc_lite.sv
  - target: test
    files:
      - bench/sram_model.sv
      - bench/smc_lite_tb.sv

//--- bench/smc_lite_tb.sv
`timescale 1ns/10ps

module smc_lite_tb;

  import smc_mem_pkg::*;

  localparam int ADDR_W     = 12;                       // Small SRAM for the bench
  localparam int MAX_CYCLES = 4000;                     // ~200 accesses of up to 20 cycles
  localparam logic [31:0] CFG_RST_EXP = {22'd0, 2'd1, 4'd3, 4'd3};
  localparam logic [31:0] CFG_MASK    = 32'h0000_03ff; // Defined fields only

  logic              pclk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [4:0]        paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [DATA_W-1:0] wb_dat_w;
  logic [BE_W-1:0]   wb_sel;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_ack;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_cs_n;
  logic              mem_oe_n;
  logic              mem_we_n;
  logic [BE_W-1:0]   mem_be_n;
  logic [DATA_W-1:0] mem_dq_out;
  logic              mem_dq_oe;
  logic [DATA_W-1:0] mem_dq_in;

  logic [31:0]       shadow_cfg;                        // Expected register
  logic [DATA_W-1:0] shadow_mem [0:(1<<ADDR_W)-1];      // Expected SRAM words
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  int                test_base = 0;
  int                cycles = 0;
  int                oe_low = 0;                        // Strobe widths so far
  int                we_low = 0;
  int                cs_high = 0;                       // Gap between accesses
  int                gap_turn = 0;
  bit                seen_cs = 1'b0;

  smc_lite #(
    .MEM_ADDR_W (ADDR_W)
  ) dut (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_sel     (wb_sel),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .mem_addr   (mem_addr),
    .mem_cs_n   (mem_cs_n),
    .mem_oe_n   (mem_oe_n),
    .mem_we_n   (mem_we_n),
    .mem_be_n   (mem_be_n),
    .mem_dq_out (mem_dq_out),
    .mem_dq_oe  (mem_dq_oe),
    .mem_dq_in  (mem_dq_in)
  );

  sram_model #(
    .MEM_ADDR_W (ADDR_W)
  ) u_sram (
    .mem_addr   (mem_addr),
    .mem_cs_n   (mem_cs_n),
    .mem_oe_n   (mem_oe_n),
    .mem_we_n   (mem_we_n),
    .mem_be_n   (mem_be_n),
    .mem_dq_out (mem_dq_out),
    .mem_dq_oe  (mem_dq_oe),
    .mem_dq_in  (mem_dq_in)
  );

  initial
  begin
    pclk = 1'b0;
    forever #50 pclk = ~pclk;                           // 100 ns period
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      pass_cnt++;
    else
    begin
      fail_cnt++;
      $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(negedge pclk);
    psel   = 1'b1;                                      // Setup cycle
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(negedge pclk);
    penable = 1'b1;                                     // Access cycle
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    if (addr == 5'h00)
      shadow_cfg = data & CFG_MASK;                     // Reserved bits dropped
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(negedge pclk);
    psel  = 1'b1;
    paddr = addr;
    @(negedge pclk);
    penable = 1'b1;
    @(negedge pclk);
    data    = prdata;                                   // Still in the access cycle
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // One Wishbone classic cycle, latency counted in falling edges
  task automatic wb_access(input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat, input logic [BE_W-1:0] sel,
                           input bit chk_lat, output logic [DATA_W-1:0] rdat);
    int ws;
    int lat;
    ws  = we ? int'(shadow_cfg[7:4]) : int'(shadow_cfg[3:0]);
    lat = 0;
    @(negedge pclk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = sel;
    do
    begin
      @(negedge pclk);
      lat++;
    end
    while (!wb_ack);
    rdat = wb_dat_r;
    @(negedge pclk);                                    // Hold stb over the ack edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (chk_lat)
      check_val("ack latency", lat, ws + 4);
    if (we)
      for (int b = 0; b < BE_W; b++)
        if (sel[b])
          shadow_mem[adr][b*8 +: 8] = dat[b*8 +: 8];
  endtask

  task automatic wait_idle();
    repeat (int'(shadow_cfg[9:8]) + 1) @(negedge pclk); // Covers turnaround
  endtask

  // Full write, partial lane merge, read back
  task automatic write_merge_read(input logic [ADDR_W-1:0] adr, input bit b2b);
    logic [DATA_W-1:0] rd;
    wb_access(1'b1, adr, $urandom, '1, !b2b, rd);
    if (!b2b)
      wait_idle();
    wb_access(1'b1, adr, $urandom, BE_W'($urandom), !b2b, rd);
    if (!b2b)
      wait_idle();
    wb_access(1'b0, adr, '0, '1, !b2b, rd);
    check_val("read data", rd, shadow_mem[adr]);
    wait_idle();
  endtask

  task automatic report_test(input string name);
    $display("Test %s finished, %0d errors", name, fail_cnt - test_base);
    test_base = fail_cnt;
  endtask

  // ----------------------------------------
  // Monitors
  // ----------------------------------------

  // Strobe width in falling-edge samples
  always @(negedge pclk)
  begin
    if (!mem_oe_n)
      oe_low++;
    else if (oe_low != 0)
    begin
      check_val("oe_n width", oe_low, int'(shadow_cfg[3:0]) + 1);
      oe_low = 0;
    end
    if (!mem_we_n)
      we_low++;
    else if (we_low != 0)
    begin
      check_val("we_n width", we_low, int'(shadow_cfg[7:4]) + 1);
      we_low = 0;
    end
  end

  // cs_n high time between accesses
  always @(negedge pclk)
  begin
    if (mem_cs_n)
      cs_high++;
    else
    begin
      if (seen_cs && cs_high != 0)
        assert (cs_high >= gap_turn + 2)
          pass_cnt++;
        else
        begin
          fail_cnt++;
          $display("** Error @ %0t: cs_n gap %0d, turnaround %0d", $time, cs_high, gap_turn);
        end
      seen_cs  = 1'b1;
      cs_high  = 0;
      gap_turn = int'(shadow_cfg[9:8]);                 // Latched for this access
    end
  end

  a_strobe_excl: assert property (@(posedge pclk) disable iff (!rst_n)
    mem_oe_n || mem_we_n)
  else
  begin
    fail_cnt++;
    $display("Protocol violation at %0t: mem_oe_n and mem_we_n low together", $time);
  end

  a_cs_with_strobe: assert property (@(posedge pclk) disable iff (!rst_n)
    (!mem_oe_n || !mem_we_n) |-> !mem_cs_n)
  else
  begin
    fail_cnt++;
    $display("Protocol violation at %0t: strobe low while mem_cs_n is high", $time);
  end

  always @(posedge pclk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  initial
  begin
    logic [DATA_W-1:0] rd;
    logic [31:0]       val;
    logic [ADDR_W-1:0] adr;
    logic [4:0]        off;
    void'($urandom(32'hb3be_5868));
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    wb_sel     = '0;
    shadow_cfg = CFG_RST_EXP;
    repeat (10) @(negedge pclk);
    rst_n = 1'b1;

    // Idle pins: cs_n, oe_n, we_n, be_n high, dq_oe and ack low
    check_val("idle pins", 32'({mem_cs_n, mem_oe_n, mem_we_n, mem_be_n, mem_dq_oe, wb_ack}),
              32'({3'b111, 4'hf, 1'b0, 1'b0}));
    apb_read(5'h00, val);
    check_val("cfg after reset", val, CFG_RST_EXP);
    apb_read(5'h04, val);
    check_val("status after reset", val, 32'h0);
    report_test("1 reset state");

    val = $urandom;
    apb_write(5'h00, val);
    apb_read(5'h00, rd);
    check_val("cfg readback", rd, val & CFG_MASK);
    for (int i = 0; i < 6; i++)
    begin
      off = 5'($urandom % 31 + 1);                      // Anything but the config offset
      apb_write(off, $urandom);
      apb_read(5'h00, rd);
      check_val("cfg after unmapped write", rd, shadow_cfg);
      apb_read(off, rd);
      check_val("unmapped read", rd, 32'h0);            // Idle status reads zero too
    end
    report_test("2 register access");

    apb_write(5'h00, {22'd0, 2'd1, 4'd1, 4'd2});        // Short timing for bulk traffic
    for (int i = 0; i < 24; i++)
      write_merge_read(ADDR_W'($urandom), 1'b0);
    report_test("3 byte lanes");

    for (int r = 0; r < 6; r++)
    begin
      apb_write(5'h00, $urandom);                       // Random waits and turnaround
      write_merge_read(ADDR_W'($urandom), 1'b0);
    end
    report_test("4 wait states");

    for (int r = 0; r < 5; r++)
    begin
      apb_write(5'h00, $urandom);
      write_merge_read(ADDR_W'($urandom), 1'b1);        // Back to back
    end
    report_test("5 strobes and gap");

    apb_write(5'h00, {22'd0, 2'd2, 4'd4, 4'd12});
    adr = ADDR_W'($urandom);
    fork
      wb_access(1'b0, adr, '0, '1, 1'b1, rd);
      begin
        repeat (3) @(negedge pclk);
        apb_read(5'h04, val);
        check_val("status during access", val, 32'h1);
      end
    join
    check_val("read data", rd, u_sram.mem[adr]);
    wait_idle();
    apb_read(5'h04, val);
    check_val("status after access", val, 32'h0);
    report_test("6 busy status");

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- bench/sram_model.sv
`timescale 1ns/10ps

// Asynchronous SRAM with byte lanes, split data bus
module sram_model #(
  parameter int MEM_ADDR_W = 12                         // Word address width
) (
  input  logic [MEM_ADDR_W-1:0]             mem_addr,
  input  logic                              mem_cs_n,
  input  logic                              mem_oe_n,
  input  logic                              mem_we_n,
  input  logic [smc_mem_pkg::BE_W-1:0]      mem_be_n,
  input  logic [smc_mem_pkg::DATA_W-1:0]    mem_dq_out,
  input  logic                              mem_dq_oe,
  output logic [smc_mem_pkg::DATA_W-1:0]    mem_dq_in
);

  import smc_mem_pkg::*;

  localparam int DEPTH = 1 << MEM_ADDR_W;

  logic [DATA_W-1:0] mem [0:DEPTH-1];

  // Scrambled fill so untouched words differ
  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  end

  // Address, lanes and data are already stable when we_n falls
  always @(negedge mem_we_n)
  begin
    if (!mem_cs_n && mem_dq_oe)
      for (int b = 0; b < BE_W; b++)
        if (!mem_be_n[b])
          mem[mem_addr][b*8 +: 8] <= mem_dq_out[b*8 +: 8];
  end

  // Enabled lanes only, the rest read zero
  always_comb
  begin
    mem_dq_in = '0;
    if (!mem_cs_n && !mem_oe_n)
      for (int b = 0; b < BE_W; b++)
        if (!mem_be_n[b])
          mem_dq_in[b*8 +: 8] = mem[mem_addr][b*8 +: 8];
  end

endmodule

//--- verilog/smc_lite.sv
`timescale 1ns/10ps

// Static memory controller top
module smc_lite #(
  parameter int MEM_ADDR_W = 20                         // SRAM word address width
) (
  input  logic                              pclk,
  input  logic                              rst_n,
  // APB register port
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [smc_cfg_pkg::OFF_W-1:0]     paddr,
  input  logic [smc_cfg_pkg::REG_W-1:0]     pwdata,
  output logic [smc_cfg_pkg::REG_W-1:0]     prdata,
  // Wishbone host port
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [MEM_ADDR_W-1:0]             wb_adr,
  input  logic [smc_mem_pkg::DATA_W-1:0]    wb_dat_w,
  input  logic [smc_mem_pkg::BE_W-1:0]      wb_sel,
  output logic [smc_mem_pkg::DATA_W-1:0]    wb_dat_r,
  output logic                              wb_ack,
  // SRAM pins
  output logic [MEM_ADDR_W-1:0]             mem_addr,
  output logic                              mem_cs_n,
  output logic                              mem_oe_n,
  output logic                              mem_we_n,
  output logic [smc_mem_pkg::BE_W-1:0]      mem_be_n,
  output logic [smc_mem_pkg::DATA_W-1:0]    mem_dq_out,
  output logic                              mem_dq_oe,
  input  logic [smc_mem_pkg::DATA_W-1:0]    mem_dq_in
);

  import smc_cfg_pkg::*;
  import smc_mem_pkg::*;

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------

  logic             sel_cfg;
  logic             sel_stat;
  logic             wr_en;
  logic [REG_W-1:0] wdata;
  logic [REG_W-1:0] cfg_rdata;
  logic [REG_W-1:0] stat_rdata;

  logic [WS_W-1:0]  ws_rd;       // Timing into the sequencer
  logic [WS_W-1:0]  ws_wr;
  logic [TA_W-1:0]  turn;

  logic                  req;    // Host request handoff
  logic                  req_we;
  logic [MEM_ADDR_W-1:0] req_adr;
  logic [DATA_W-1:0]     req_dat;
  logic [BE_W-1:0]       req_sel;
  logic                  busy;
  logic                  done;
  logic [DATA_W-1:0]     rd_data;

  // ----------------------------------------
  // Register side
  // ----------------------------------------

  smc_apb_if u_apb_if (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .sel_cfg    (sel_cfg),
    .sel_stat   (sel_stat),
    .wr_en      (wr_en),
    .wdata      (wdata),
    .cfg_rdata  (cfg_rdata),
    .stat_rdata (stat_rdata)
  );

  smc_cfreg u_cfreg (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .sel_cfg    (sel_cfg),
    .sel_stat   (sel_stat),
    .wr_en      (wr_en),
    .wdata      (wdata),
    .busy       (busy),
    .cfg_rdata  (cfg_rdata),
    .stat_rdata (stat_rdata),
    .ws_rd      (ws_rd),
    .ws_wr      (ws_wr),
    .turn       (turn)
  );

  // ----------------------------------------
  // Host and memory side
  // ----------------------------------------

  smc_wb_if #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_wb_if (
    .pclk     (pclk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .req      (req),
    .req_we   (req_we),
    .req_adr  (req_adr),
    .req_dat  (req_dat),
    .req_sel  (req_sel),
    .busy     (busy),
    .done     (done),
    .rd_data  (rd_data)
  );

  smc_strobe_gen #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_strobe_gen (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .req        (req),
    .req_we     (req_we),
    .req_adr    (req_adr),
    .req_dat    (req_dat),
    .req_sel    (req_sel),
    .ws_rd      (ws_rd),
    .ws_wr      (ws_wr),
    .turn       (turn),
    .busy       (busy),
    .done       (done),
    .rd_data    (rd_data),
    .mem_addr   (mem_addr),
    .mem_cs_n   (mem_cs_n),
    .mem_oe_n   (mem_oe_n),
    .mem_we_n   (mem_we_n),
    .mem_be_n   (mem_be_n),
    .mem_dq_out (mem_dq_out),
    .mem_dq_oe  (mem_dq_oe),
    .mem_dq_in  (mem_dq_in)
  );

endmodule

//--- verilog/smc_strobe_gen.sv
`timescale 1ns/10ps

// Access sequencer for the external SRAM
module smc_strobe_gen #(
  parameter int MEM_ADDR_W = 20
) (
  input  logic                              pclk,
  input  logic                              rst_n,
  input  logic                              req,
  input  logic                              req_we,
  input  logic [MEM_ADDR_W-1:0]             req_adr,
  input  logic [smc_mem_pkg::DATA_W-1:0]    req_dat,
  input  logic [smc_mem_pkg::BE_W-1:0]      req_sel,
  input  logic [smc_cfg_pkg::WS_W-1:0]      ws_rd,
  input  logic [smc_cfg_pkg::WS_W-1:0]      ws_wr,
  input  logic [smc_cfg_pkg::TA_W-1:0]      turn,
  output logic                              busy,
  output logic                              done,       // One cycle pulse
  output logic [smc_mem_pkg::DATA_W-1:0]    rd_data,
  output logic [MEM_ADDR_W-1:0]             mem_addr,
  output logic                              mem_cs_n,
  output logic                              mem_oe_n,
  output logic                              mem_we_n,
  output logic [smc_mem_pkg::BE_W-1:0]      mem_be_n,
  output logic [smc_mem_pkg::DATA_W-1:0]    mem_dq_out,
  output logic                              mem_dq_oe,
  input  logic [smc_mem_pkg::DATA_W-1:0]    mem_dq_in
);

  import smc_cfg_pkg::*;
  import smc_mem_pkg::*;

  access_state_t   state;
  logic            start;      // Accepted, SETUP on next edge
  logic [WS_W-1:0] ws_rd_q;    // Timing latched at acceptance
  logic [WS_W-1:0] ws_wr_q;
  logic [TA_W-1:0] turn_q;
  logic [WS_W-1:0] cnt;        // Strobe and turnaround down-counter
  logic            strobe_end; // Last strobe cycle

  assign busy       = (state != IDLE) | start;
  assign strobe_end = (state == STROBE) && (cnt == '0);

  // ----------------------------------------
  // Acceptance
  // ----------------------------------------

  // Direction is not known yet, so both wait-state fields are kept
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start   <= 1'b0;
      ws_rd_q <= '0;
      ws_wr_q <= '0;
      turn_q  <= '0;
    end
    else
    begin
      start <= req & ~busy;
      if (req & ~busy)
      begin
        ws_rd_q <= ws_rd;
        ws_wr_q <= ws_wr;
        turn_q  <= turn;
      end
    end
  end

  // ----------------------------------------
  // Sequencer and strobes
  // ----------------------------------------

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      cnt       <= '0;
      done      <= 1'b0;
      mem_cs_n  <= 1'b1;
      mem_oe_n  <= 1'b1;
      mem_we_n  <= 1'b1;
      mem_be_n  <= '1;
      mem_dq_oe <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        IDLE:
          if (start)
          begin
            state     <= SETUP;
            mem_cs_n  <= 1'b0;             // Chip select for setup
            mem_be_n  <= ~req_sel;
            mem_dq_oe <= req_we;           // Drive write data early
          end
        SETUP:
        begin
          state    <= STROBE;
          cnt      <= req_we ? ws_wr_q : ws_rd_q;
          mem_oe_n <= req_we;
          mem_we_n <= ~req_we;
        end
        STROBE:
          if (cnt == '0)
          begin
            mem_cs_n  <= 1'b1;
            mem_oe_n  <= 1'b1;
            mem_we_n  <= 1'b1;
            mem_be_n  <= '1;
            mem_dq_oe <= 1'b0;
            done      <= 1'b1;
            if (turn_q == '0)
              state <= IDLE;               // No turnaround
            else
            begin
              state <= TURN;
              cnt   <= WS_W'(turn_q - 1'b1);
            end
          end
          else
            cnt <= cnt - 1'b1;
        TURN:
          if (cnt == '0)
            state <= IDLE;
          else
            cnt <= cnt - 1'b1;
        default:
          state <= IDLE;
      endcase
    end
  end

  // Address and data payload
  always_ff @(posedge pclk)
  begin
    if (state == IDLE && start)
    begin
      mem_addr   <= req_adr;
      mem_dq_out <= req_dat;
    end
    if (strobe_end && !req_we)
      rd_data <= mem_dq_in;                // Sampled as oe_n rises
  end

  // Never both strobes at once
  a_strobe_excl: assert property (@(posedge pclk) disable iff (!rst_n)
    !(!mem_oe_n && !mem_we_n));

  // Completion is a single pulse
  a_done_pulse: assert property (@(posedge pclk) disable iff (!rst_n)
    done |=> !done);

endmodule

//--- verilog/smc_wb_if.sv
`timescale 1ns/10ps

// Wishbone classic slave in front of the sequencer
module smc_wb_if #(
  parameter int MEM_ADDR_W = 20                         // Word address width
) (
  input  logic                              pclk,
  input  logic                              rst_n,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [MEM_ADDR_W-1:0]             wb_adr,
  input  logic [smc_mem_pkg::DATA_W-1:0]    wb_dat_w,
  input  logic [smc_mem_pkg::BE_W-1:0]      wb_sel,
  output logic [smc_mem_pkg::DATA_W-1:0]    wb_dat_r,
  output logic                              wb_ack,
  output logic                              req,        // One cycle per request
  output logic                              req_we,
  output logic [MEM_ADDR_W-1:0]             req_adr,
  output logic [smc_mem_pkg::DATA_W-1:0]    req_dat,
  output logic [smc_mem_pkg::BE_W-1:0]      req_sel,
  input  logic                              busy,
  input  logic                              done,       // Access complete
  input  logic [smc_mem_pkg::DATA_W-1:0]    rd_data
);

  import smc_mem_pkg::*;

  logic              pending;  // Current stb already handed over
  logic [DATA_W-1:0] dat_q;    // Last read word

  // ----------------------------------------
  // Request handoff
  // ----------------------------------------

  assign req = wb_cyc & wb_stb & ~busy & ~pending;

  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
      pending <= 1'b0;
    else if (req)
      pending <= 1'b1;
    else if (done)
      pending <= 1'b0;    // Master drops stb after ack
  end

  // Request fields held until done
  always_ff @(posedge pclk)
  begin
    if (req)
    begin
      req_we  <= wb_we;
      req_adr <= wb_adr;
      req_dat <= wb_dat_w;
      req_sel <= wb_sel;
    end
  end

  // ----------------------------------------
  // Response
  // ----------------------------------------

  always_ff @(posedge pclk)
  begin
    if (done)
      dat_q <= rd_data;
  end

  assign wb_dat_r = done ? rd_data : dat_q;   // Fresh word during ack
  assign wb_ack   = done;

  // Ack lands inside the request
  a_ack_in_stb: assert property (@(posedge pclk) disable iff (!rst_n)
    wb_ack |-> wb_stb);

endmodule

//--- verilog/smc_cfreg.sv
`timescale 1ns/10ps

// Timing configuration and status registers
module smc_cfreg (
  input  logic                              pclk,
  input  logic                              rst_n,
  input  logic                              sel_cfg,
  input  logic                              sel_stat,
  input  logic                              wr_en,
  input  logic [smc_cfg_pkg::REG_W-1:0]     wdata,
  input  logic                              busy,       // From sequencer
  output logic [smc_cfg_pkg::REG_W-1:0]     cfg_rdata,
  output logic [smc_cfg_pkg::REG_W-1:0]     stat_rdata,
  output logic [smc_cfg_pkg::WS_W-1:0]      ws_rd,      // Read wait states
  output logic [smc_cfg_pkg::WS_W-1:0]      ws_wr,      // Write wait states
  output logic [smc_cfg_pkg::TA_W-1:0]      turn        // Turnaround cycles
);

  import smc_cfg_pkg::*;

  logic cfg_we;

  assign cfg_we = sel_cfg & wr_en;

  // ----------------------------------------
  // Configuration storage
  // ----------------------------------------

  // Only the defined fields are kept
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ws_rd <= CFG_RESET[CFG_RD_LSB +: WS_W];
      ws_wr <= CFG_RESET[CFG_WR_LSB +: WS_W];
      turn  <= CFG_RESET[CFG_TA_LSB +: TA_W];
    end
    else if (cfg_we)
    begin
      ws_rd <= wdata[CFG_RD_LSB +: WS_W];
      ws_wr <= wdata[CFG_WR_LSB +: WS_W];
      turn  <= wdata[CFG_TA_LSB +: TA_W];
    end
  end

  // Rebuild register, reserved bits read zero
  always_comb
  begin
    cfg_rdata = '0;
    cfg_rdata[CFG_RD_LSB +: WS_W] = ws_rd;
    cfg_rdata[CFG_WR_LSB +: WS_W] = ws_wr;
    cfg_rdata[CFG_TA_LSB +: TA_W] = turn;
  end

  // ----------------------------------------
  // Status view
  // ----------------------------------------

  always_comb
  begin
    stat_rdata = '0;
    if (sel_stat)
      stat_rdata[STAT_BUSY_BIT] = busy;   // Access in progress
  end

  // Fields only move on a selected write
  a_cfg_hold: assert property (@(posedge pclk) disable iff (!rst_n)
    !cfg_we |=> $stable({ws_rd, ws_wr, turn}));

endmodule

//--- verilog/smc_apb_if.sv
`timescale 1ns/10ps

// APB register port of the controller
module smc_apb_if (
  input  logic                              pclk,       // APB clock
  input  logic                              rst_n,
  input  logic                              psel,       // APB select
  input  logic                              penable,    // Access phase
  input  logic                              pwrite,     // Write strobe
  input  logic [smc_cfg_pkg::OFF_W-1:0]     paddr,
  input  logic [smc_cfg_pkg::REG_W-1:0]     pwdata,
  output logic [smc_cfg_pkg::REG_W-1:0]     prdata,
  output logic                              sel_cfg,    // Config register select
  output logic                              sel_stat,   // Status register select
  output logic                              wr_en,
  output logic [smc_cfg_pkg::REG_W-1:0]     wdata,
  input  logic [smc_cfg_pkg::REG_W-1:0]     cfg_rdata,
  input  logic [smc_cfg_pkg::REG_W-1:0]     stat_rdata
);

  import smc_cfg_pkg::*;

  logic access;   // Access cycle of a transfer

  assign access = psel & penable;

  // ----------------------------------------
  // Register selects
  // ----------------------------------------

  always_comb
  begin : p_addr_decode
    sel_cfg  = 1'b0;
    sel_stat = 1'b0;
    if (access)
    begin
      sel_cfg  = (paddr == CFG_OFFSET);
      sel_stat = (paddr == STAT_OFFSET);
    end
  end

  assign wr_en = access & pwrite;   // Ends with the access cycle
  assign wdata = pwdata;

  // Read mux, zero for unmapped offsets and outside the access cycle
  always_comb
  begin : p_rdata_mux
    prdata = '0;
    if (sel_cfg)
      prdata = cfg_rdata;
    else if (sel_stat)
      prdata = stat_rdata;
  end

  // Selects stay one-hot over every transfer
  a_sel_onehot: assert property (@(posedge pclk) disable iff (!rst_n)
    !(sel_cfg && sel_stat));

endmodule

//--- verilog/smc_mem_pkg.sv
package smc_mem_pkg;

  // ----------------------------------------
  // External memory bus
  // ----------------------------------------

  parameter int DATA_W = 32;                     // Word access
  parameter int BE_W   = DATA_W / 8;             // One lane per byte

  // ----------------------------------------
  // Access sequencing
  // ----------------------------------------

  // IDLE waits for a request
  // SETUP has cs_n low with address and lanes driven
  // STROBE holds oe_n or we_n low for WS+1 cycles
  // TURN keeps the bus quiet before the next access
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    SETUP  = 2'b01,
    STROBE = 2'b10,
    TURN   = 2'b11
  } access_state_t;

endpackage

//--- verilog/smc_cfg_pkg.sv
package smc_cfg_pkg;

  // ----------------------------------------
  // APB register map
  // ----------------------------------------

  parameter int REG_W = 32;                      // APB data width
  parameter int OFF_W = 5;                       // Matches paddr

  parameter logic [OFF_W-1:0] CFG_OFFSET  = 5'h00; // Timing config
  parameter logic [OFF_W-1:0] STAT_OFFSET = 5'h04; // Read-only status

  // ----------------------------------------
  // Configuration fields
  // ----------------------------------------

  parameter int WS_W = 4;                        // One wait-state field
  parameter int TA_W = 2;                        // Turnaround field

  parameter int CFG_RD_LSB = 0;                  // Read wait states [3:0]
  parameter int CFG_WR_LSB = 4;                  // Write wait states [7:4]
  parameter int CFG_TA_LSB = 8;                  // Turnaround [9:8]

  // Status bits
  parameter int STAT_BUSY_BIT = 0;

  // Reset timing of 3 read waits, 3 write waits, 1 turnaround cycle
  parameter logic [WS_W-1:0] RST_WS_RD = 4'd3;
  parameter logic [WS_W-1:0] RST_WS_WR = 4'd3;
  parameter logic [TA_W-1:0] RST_TURN  = 2'd1;

  parameter logic [REG_W-1:0] CFG_RESET =
    (REG_W'(RST_WS_RD) << CFG_RD_LSB) |
    (REG_W'(RST_WS_WR) << CFG_WR_LSB) |
    (REG_W'(RST_TURN)  << CFG_TA_LSB);           // 32'h0000_0133

endpackage
